/* control_settings.svh */
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

// opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes for the R-type opcode
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2a

// ALU operations
`define ALU_PASS 3'd0
`define ALU_ADD  3'd1
`define ALU_SUB  3'd2
`define ALU_AND  3'd3
`define ALU_CMP  3'd7

// shifter operations
`define SH_NONE   3'd0
`define SH_LOAD   3'd1
`define SH_LEFT   3'd2
`define SH_RIGHTL 3'd3
`define SH_RIGHTA 3'd4

// register file write address
`define DST_RT 2'd0
`define DST_RD 2'd3

// register file write data
`define DS_ALUOUT 4'd0
`define DS_MDR    4'd1
`define DS_LT     4'd6
`define DS_SHIFT  4'd7

// ALU operand selects
`define SRCA_PC    2'd0
`define SRCA_REGA  2'd2
`define SRCB_REGB  2'd0
`define SRCB_FOUR  2'd1
`define SRCB_IMM   2'd2
`define SRCB_BROFF 2'd3

// PC source
`define PCS_ALURES 2'd0
`define PCS_BRANCH 2'd1
`define PCS_JUMP   2'd2
`define PCS_EXCEPT 2'd3

// memory address source
`define IORD_PC     3'd0
`define IORD_EXCEPT 3'd1
`define IORD_ALURES 3'd2
`define IORD_ALUOUT 3'd3

`endif

/* controlPkg.sv */
`include "control_settings.svh"

package controlPkg;

    typedef logic [`OPCODE_W-1:0] opcodeT;
    typedef logic [`FUNCT_W-1:0]  functT;

    typedef logic [2:0] aluOpT;
    typedef logic [2:0] shiftOpT;
    typedef logic [1:0] regDstT;
    typedef logic [3:0] dataSrcT;
    typedef logic [1:0] aluSrcT;   // shared by operand A and B
    typedef logic [1:0] pcSrcT;
    typedef logic [2:0] iorDT;

    // closed set of decoded instructions
    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsSll,
        clsSrl,
        clsSra,
        clsAddi,
        clsAddiu,
        clsBeq,
        clsBne,
        clsJ,
        clsLw,
        clsSw,
        clsIllegal
    } instrClassT;

    typedef enum logic [4:0] {
        fetch1,
        fetch2,
        fetch3,
        decode1,
        decode2,
        execute,
        aluOutRd,
        aluOutRt,
        writeBack,      // ALU result lands here once overflow is cleared
        shiftRun,
        shiftEndRd,
        branchTest,
        lw2,
        lw3,
        lw4,
        sw2,
        exceptOpcode1,
        exceptOpcode2,
        exceptOverflow1,
        exceptOverflow2,
        endExcept1,
        endExcept2,
        endExcept3,
        finish
    } ctrlStateT;

endpackage

/* instrDecoder.sv */
`include "control_settings.svh"

module instrDecoder (
    input  controlPkg::opcodeT     opcode,
    input  controlPkg::functT      funct,
    output controlPkg::instrClassT instrClass
);
    import controlPkg::*;

    always_comb begin
        instrClass = clsIllegal; // anything not listed traps
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD: instrClass = clsAdd;
                    `FN_SUB: instrClass = clsSub;
                    `FN_AND: instrClass = clsAnd;
                    `FN_SLT: instrClass = clsSlt;
                    `FN_SLL: instrClass = clsSll;
                    `FN_SRL: instrClass = clsSrl;
                    `FN_SRA: instrClass = clsSra;
                    default: instrClass = clsIllegal;
                endcase
            end
            `OP_ADDI: begin
                instrClass = clsAddi;
            end
            `OP_ADDIU: begin
                instrClass = clsAddiu;
            end
            `OP_BEQ: begin
                instrClass = clsBeq;
            end
            `OP_BNE: begin
                instrClass = clsBne;
            end
            `OP_J: begin
                instrClass = clsJ;
            end
            `OP_LW: begin
                instrClass = clsLw;
            end
            `OP_SW: begin
                instrClass = clsSw;
            end
            default: begin
                instrClass = clsIllegal;
            end
        endcase
    end

endmodule

/* ctrlSequencer.sv */
module ctrlSequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    input  logic                   overflow,
    output controlPkg::ctrlStateT  state,
    output controlPkg::instrClassT curClass
);
    import controlPkg::*;

    ctrlStateT nextState;
    logic      trapsOverflow;

    // only the signed adds and sub raise the overflow exception
    assign trapsOverflow = overflow &&
                           (curClass == clsAdd || curClass == clsSub || curClass == clsAddi);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fetch1;
            curClass <= clsIllegal;
        end else begin
            state <= nextState;
            if (state == decode2) begin
                curClass <= instrClass; // fields are stable since decode1
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            fetch1:  nextState = fetch2;
            fetch2:  nextState = fetch3;
            fetch3:  nextState = decode1;
            decode1: nextState = decode2;
            decode2: nextState = execute;
            execute: begin
                case (curClass)
                    clsAdd, clsSub, clsAnd: nextState = aluOutRd;
                    clsAddi, clsAddiu:      nextState = aluOutRt;
                    clsSll, clsSrl, clsSra: nextState = shiftRun;
                    clsBeq, clsBne:         nextState = branchTest;
                    clsLw:                  nextState = lw2;
                    clsSw:                  nextState = sw2;
                    clsSlt, clsJ:           nextState = finish; // done in one cycle
                    default:                nextState = exceptOpcode1;
                endcase
            end
            aluOutRd, aluOutRt: begin
                if (trapsOverflow) begin
                    nextState = exceptOverflow1;
                end else begin
                    nextState = writeBack;
                end
            end
            writeBack:       nextState = finish;
            shiftRun:        nextState = shiftEndRd;
            shiftEndRd:      nextState = finish;
            branchTest:      nextState = finish;
            lw2:             nextState = lw3;
            lw3:             nextState = lw4;  // memory read latency
            lw4:             nextState = finish;
            sw2:             nextState = finish;
            exceptOpcode1:   nextState = exceptOpcode2;
            exceptOpcode2:   nextState = endExcept1;
            exceptOverflow1: nextState = exceptOverflow2;
            exceptOverflow2: nextState = endExcept1;
            endExcept1:      nextState = endExcept2;
            endExcept2:      nextState = endExcept3;
            endExcept3:      nextState = finish;
            finish:          nextState = fetch1;
            default:         nextState = fetch1;
        endcase
    end

endmodule

/* ctrlEncoder.sv */
`include "control_settings.svh"

module ctrlEncoder (
    input  controlPkg::ctrlStateT  state,
    input  controlPkg::instrClassT curClass,
    input  logic                   eq,
    output controlPkg::aluOpT      aluOp,
    output controlPkg::shiftOpT    shiftOp,
    output controlPkg::iorDT       iorD,
    output controlPkg::regDstT     regDst,
    output controlPkg::dataSrcT    dataSrc,
    output controlPkg::aluSrcT     aluSrcA,
    output controlPkg::aluSrcT     aluSrcB,
    output controlPkg::pcSrcT      pcSrc,
    output logic                   pcWrite,
    output logic                   memWrite,
    output logic                   irWrite,
    output logic                   regWrite,
    output logic                   aluOutWrite,
    output logic                   epcWrite,
    output logic                   regAWrite,
    output logic                   regBWrite,
    output logic                   mdrWrite
);
    import controlPkg::*;

    logic branchTaken;

    assign branchTaken = (curClass == clsBeq && eq) || (curClass == clsBne && !eq);

    always_comb begin
        aluOp       = `ALU_PASS;
        shiftOp     = `SH_NONE;
        iorD        = `IORD_PC;
        regDst      = `DST_RT;
        dataSrc     = `DS_ALUOUT;
        aluSrcA     = `SRCA_PC;
        aluSrcB     = `SRCB_REGB;
        pcSrc       = `PCS_ALURES;
        pcWrite     = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aluOutWrite = 1'b0;
        epcWrite    = 1'b0;
        regAWrite   = 1'b0;
        regBWrite   = 1'b0;
        mdrWrite    = 1'b0;
        case (state)
            fetch1, fetch2: begin
                aluSrcA = `SRCA_PC;
                aluSrcB = `SRCB_FOUR;
                aluOp   = `ALU_ADD;      // PC + 4
                iorD    = `IORD_PC;
                pcWrite = (state == fetch2);
            end
            fetch3: irWrite = 1'b1;
            decode1: begin
                aluSrcA     = `SRCA_PC;
                aluSrcB     = `SRCB_BROFF;  // branch target precomputed
                aluOp       = `ALU_ADD;
                aluOutWrite = 1'b1;
            end
            decode2: begin
                regAWrite = 1'b1;
                regBWrite = 1'b1;
            end
            execute: begin
                aluSrcA = `SRCA_REGA;
                case (curClass)
                    clsAdd, clsSub, clsAnd: begin
                        aluSrcB     = `SRCB_REGB;
                        aluOp       = (curClass == clsAdd) ? `ALU_ADD :
                                      (curClass == clsSub) ? `ALU_SUB : `ALU_AND;
                        aluOutWrite = 1'b1;
                    end
                    clsAddi, clsAddiu, clsSw: begin
                        aluSrcB     = `SRCB_IMM;
                        aluOp       = `ALU_ADD;
                        aluOutWrite = 1'b1;
                    end
                    clsSlt: begin
                        aluOp    = `ALU_CMP;
                        regWrite = 1'b1;
                        dataSrc  = `DS_LT;
                        regDst   = `DST_RD;
                    end
                    clsSll, clsSrl, clsSra: shiftOp = `SH_LOAD;
                    clsBeq, clsBne:         aluOp = `ALU_CMP; // eq valid next cycle
                    clsJ: begin
                        pcWrite = 1'b1;
                        pcSrc   = `PCS_JUMP;
                    end
                    clsLw: begin
                        aluSrcB = `SRCB_IMM;
                        aluOp   = `ALU_ADD;
                        iorD    = `IORD_ALURES;  // address straight from the ALU
                    end
                    default: aluSrcA = `SRCA_PC;
                endcase
            end
            writeBack: begin
                regWrite = 1'b1;
                dataSrc  = `DS_ALUOUT;
                regDst   = (curClass == clsAddi || curClass == clsAddiu) ? `DST_RT : `DST_RD;
            end
            shiftRun: begin
                shiftOp = (curClass == clsSll) ? `SH_LEFT :
                          (curClass == clsSrl) ? `SH_RIGHTL : `SH_RIGHTA;
            end
            shiftEndRd: begin
                regWrite = 1'b1;
                dataSrc  = `DS_SHIFT;
                regDst   = `DST_RD;
            end
            branchTest: begin
                pcWrite = branchTaken;
                pcSrc   = `PCS_BRANCH;
            end
            lw2: mdrWrite = 1'b1;
            lw4: begin
                regWrite = 1'b1;
                dataSrc  = `DS_MDR;
                regDst   = `DST_RT;
            end
            sw2: begin
                memWrite = 1'b1;
                iorD     = `IORD_ALUOUT;
            end
            exceptOpcode1, exceptOverflow1: begin
                epcWrite = 1'b1;   // EPC takes PC - 4
                aluSrcA  = `SRCA_PC;
                aluSrcB  = `SRCB_FOUR;
                aluOp    = `ALU_SUB;
            end
            exceptOpcode2, exceptOverflow2: iorD = `IORD_EXCEPT;
            endExcept3: begin
                pcWrite  = 1'b1;
                pcSrc    = `PCS_EXCEPT;
                mdrWrite = 1'b1;
            end
            default: irWrite = 1'b0;
        endcase
    end

endmodule

/* controlUnit.sv */
module controlUnit (
    input  logic                clk,
    input  logic                reset,
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::functT   funct,
    input  logic                overflow,
    input  logic                eq,
    output controlPkg::aluOpT   aluOp,
    output controlPkg::shiftOpT shiftOp,
    output controlPkg::iorDT    iorD,
    output controlPkg::regDstT  regDst,
    output controlPkg::dataSrcT dataSrc,
    output controlPkg::aluSrcT  aluSrcA,
    output controlPkg::aluSrcT  aluSrcB,
    output controlPkg::pcSrcT   pcSrc,
    output logic                pcWrite,
    output logic                memWrite,
    output logic                irWrite,
    output logic                regWrite,
    output logic                aluOutWrite,
    output logic                epcWrite,
    output logic                regAWrite,
    output logic                regBWrite,
    output logic                mdrWrite
);
    import controlPkg::*;

    instrClassT instrClass;   // decoded live from the IR fields
    instrClassT curClass;     // latched in decode2
    ctrlStateT  state;

    instrDecoder i_decoder (
        .opcode    (opcode),
        .funct     (funct),
        .instrClass(instrClass)
    );

    ctrlSequencer i_sequencer (
        .clk       (clk),
        .reset     (reset),
        .instrClass(instrClass),
        .overflow  (overflow),
        .state     (state),
        .curClass  (curClass)
    );

    ctrlEncoder i_encoder (
        .state      (state),
        .curClass   (curClass),
        .eq         (eq),
        .aluOp      (aluOp),
        .shiftOp    (shiftOp),
        .iorD       (iorD),
        .regDst     (regDst),
        .dataSrc    (dataSrc),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .pcSrc      (pcSrc),
        .pcWrite    (pcWrite),
        .memWrite   (memWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aluOutWrite(aluOutWrite),
        .epcWrite   (epcWrite),
        .regAWrite  (regAWrite),
        .regBWrite  (regBWrite),
        .mdrWrite   (mdrWrite)
    );

endmodule

/* tbControlUnit.sv */
`include "control_settings.svh"

module tbControlUnit;
    timeunit 1ns;
    timeprecision 100ps;
    import controlPkg::*;

    localparam int MaxCycles = 40;   // longest instruction is 13

    logic    clk;
    logic    reset;
    opcodeT  opcode;
    functT   funct;
    logic    overflow;
    logic    eq;
    aluOpT   aluOp;
    shiftOpT shiftOp;
    iorDT    iorD;
    regDstT  regDst;
    dataSrcT dataSrc;
    aluSrcT  aluSrcA;
    aluSrcT  aluSrcB;
    pcSrcT   pcSrc;
    logic    pcWrite, memWrite, irWrite, regWrite, aluOutWrite;
    logic    epcWrite, regAWrite, regBWrite, mdrWrite;

    // trace of one instruction, from its irWrite to the next one
    int      cycles, nReg, nMem, nEpc, nMdr, regCycle, mdrCycle;
    regDstT  wbDst;
    dataSrcT wbSrc;
    iorDT    memAddr, execIorD;
    aluOpT   execAluOp, epcAluOp;
    aluSrcT  epcSrcA, epcSrcB;
    pcSrcT   pcSrcs[$];
    shiftOpT shifts[$];

    controlUnit i_dut (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .overflow(overflow), .eq(eq), .aluOp(aluOp), .shiftOp(shiftOp),
        .iorD(iorD), .regDst(regDst), .dataSrc(dataSrc), .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB), .pcSrc(pcSrc), .pcWrite(pcWrite), .memWrite(memWrite),
        .irWrite(irWrite), .regWrite(regWrite), .aluOutWrite(aluOutWrite),
        .epcWrite(epcWrite), .regAWrite(regAWrite), .regBWrite(regBWrite),
        .mdrWrite(mdrWrite)
    );

    always #10 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        reportFailure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkAluOp(input string name, input aluOpT got, input aluOpT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkShiftOp(input string name, input shiftOpT got, input shiftOpT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkRegDst(input string name, input regDstT got, input regDstT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkDataSrc(input string name, input dataSrcT got, input dataSrcT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkAluSrc(input string name, input aluSrcT got, input aluSrcT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkPcSrc(input string name, input pcSrcT got, input pcSrcT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkIorD(input string name, input iorDT got, input iorDT exp);
        if (got !== exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkLength(input string name, input int got, input int exp);
        if (got != exp) reportMismatch(name, got, exp);
    endtask

    task automatic checkNoWrites();
        checkBit("pcWrite", pcWrite, 1'b0);
        checkBit("memWrite", memWrite, 1'b0);
        checkBit("irWrite", irWrite, 1'b0);
        checkBit("regWrite", regWrite, 1'b0);
        checkBit("aluOutWrite", aluOutWrite, 1'b0);
        checkBit("epcWrite", epcWrite, 1'b0);
        checkBit("regAWrite", regAWrite, 1'b0);
        checkBit("regBWrite", regBWrite, 1'b0);
        checkBit("mdrWrite", mdrWrite, 1'b0);
    endtask

    // leaves the testbench on the falling edge that shows the first irWrite
    task automatic applyReset();
        int  i;
        logic found;
        reset = 1'b1;
        repeat (8) begin
            @(negedge clk);
            checkNoWrites();
        end
        reset = 1'b0;
        found = 1'b0;
        for (i = 0; i < MaxCycles && !found; i++) begin
            @(negedge clk);
            found = pcWrite | memWrite | irWrite | regWrite | aluOutWrite |
                    epcWrite | regAWrite | regBWrite | mdrWrite;
        end
        if (!found) reportFailure("no write pulse appeared after reset was released");
        checkBit("pcWrite", pcWrite, 1'b1);   // fetch2
        checkPcSrc("pcSrc", pcSrc, `PCS_ALURES);
        checkAluSrc("aluSrcB", aluSrcB, `SRCB_FOUR);
        checkBit("irWrite", irWrite, 1'b0);
        @(negedge clk);
        checkBit("irWrite", irWrite, 1'b1);
        checkBit("pcWrite", pcWrite, 1'b0);
    endtask

    // fields go out right after irWrite, then every write pulse is traced
    task automatic runInstr(input opcodeT op, input functT fn, input logic ovf, input logic eqIn);
        int   i;
        logic seen;
        opcode   = op;
        funct    = fn;
        overflow = ovf;
        eq       = eqIn;
        nReg     = 0;
        nMem     = 0;
        nEpc     = 0;
        nMdr     = 0;
        regCycle = 0;
        mdrCycle = 0;
        cycles   = 0;
        pcSrcs.delete();
        shifts.delete();
        seen = 1'b0;
        for (i = 0; i < MaxCycles && !seen; i++) begin
            @(negedge clk);
            cycles++;
            if (cycles == 3) begin   // execute
                execAluOp = aluOp;
                execIorD  = iorD;
            end
            if (shiftOp != `SH_NONE) shifts.push_back(shiftOp);
            if (pcWrite) pcSrcs.push_back(pcSrc);
            if (regWrite) begin
                nReg++;
                regCycle = cycles;
                wbDst    = regDst;
                wbSrc    = dataSrc;
            end
            if (memWrite) begin
                nMem++;
                memAddr = iorD;
            end
            if (epcWrite) begin
                nEpc++;
                epcAluOp = aluOp;
                epcSrcA  = aluSrcA;
                epcSrcB  = aluSrcB;
            end
            if (mdrWrite) begin
                nMdr++;
                mdrCycle = cycles;
            end
            seen = irWrite;
        end
        if (!seen) reportFailure("the next irWrite pulse did not arrive in time");
    endtask

    // the window always ends with the next fetch2 PC increment
    task automatic checkPcTrace(input logic hasExtra, input pcSrcT extraSrc);
        checkLength("pcWrite count", pcSrcs.size(), hasExtra ? 2 : 1);
        if (hasExtra) checkPcSrc("pcSrc", pcSrcs[0], extraSrc);
        checkPcSrc("pcSrc", pcSrcs[pcSrcs.size()-1], `PCS_ALURES);
    endtask

    task automatic checkException(input int expLen);
        checkLength("cycles", cycles, expLen);
        checkLength("epcWrite count", nEpc, 1);
        checkAluOp("aluOp", epcAluOp, `ALU_SUB);
        checkAluSrc("aluSrcA", epcSrcA, `SRCA_PC);
        checkAluSrc("aluSrcB", epcSrcB, `SRCB_FOUR);
        checkLength("regWrite count", nReg, 0);
        checkPcTrace(1'b1, `PCS_EXCEPT);
    endtask

    task automatic testAlu(input opcodeT op, input functT fn, input logic ovf, input aluOpT expOp,
                           input regDstT expDst, input dataSrcT expSrc, input int expLen,
                           input logic canTrap);
        runInstr(op, fn, ovf, ($urandom % 2) == 1);
        checkAluOp("aluOp", execAluOp, expOp);
        if (ovf && canTrap) begin
            checkException(13);
        end else begin
            checkLength("cycles", cycles, expLen);
            checkLength("regWrite count", nReg, 1);
            checkRegDst("regDst", wbDst, expDst);
            checkDataSrc("dataSrc", wbSrc, expSrc);
            checkLength("epcWrite count", nEpc, 0);
            checkPcTrace(1'b0, `PCS_ALURES);
        end
    endtask

    task automatic testShift(input functT fn, input shiftOpT expShift);
        runInstr(`OP_RTYPE, fn, 1'b0, 1'b0);
        checkLength("cycles", cycles, 9);
        checkLength("shiftOp steps", shifts.size(), 2);
        checkShiftOp("shiftOp", shifts[0], `SH_LOAD);
        checkShiftOp("shiftOp", shifts[1], expShift);
        checkLength("regWrite count", nReg, 1);
        checkDataSrc("dataSrc", wbSrc, `DS_SHIFT);
        checkRegDst("regDst", wbDst, `DST_RD);
    endtask

    task automatic testBranch(input opcodeT op);
        logic eqIn;
        logic taken;
        eqIn  = ($urandom % 2) == 1;
        taken = (op == `OP_BEQ) ? eqIn : !eqIn;
        runInstr(op, functT'($urandom), 1'b0, eqIn);
        checkLength("cycles", cycles, 8);
        checkAluOp("aluOp", execAluOp, `ALU_CMP);
        checkLength("regWrite count", nReg, 0);
        checkPcTrace(taken, `PCS_BRANCH);
    endtask

    task automatic testJump();
        runInstr(`OP_J, functT'($urandom), 1'b0, 1'b0);
        checkLength("cycles", cycles, 7);
        checkLength("regWrite count", nReg, 0);
        checkPcTrace(1'b1, `PCS_JUMP);
    endtask

    task automatic testLoad();
        runInstr(`OP_LW, functT'($urandom), 1'b0, 1'b0);
        checkLength("cycles", cycles, 10);
        checkIorD("iorD", execIorD, `IORD_ALURES);
        checkLength("mdrWrite count", nMdr, 1);
        checkLength("regWrite count", nReg, 1);
        checkBit("mdrWrite before regWrite", mdrCycle < regCycle, 1'b1);
        checkDataSrc("dataSrc", wbSrc, `DS_MDR);
        checkRegDst("regDst", wbDst, `DST_RT);
    endtask

    task automatic testStore();
        runInstr(`OP_SW, functT'($urandom), 1'b0, 1'b0);
        checkLength("cycles", cycles, 8);
        checkLength("memWrite count", nMem, 1);
        checkIorD("iorD", memAddr, `IORD_ALUOUT);
        checkLength("regWrite count", nReg, 0);
    endtask

    task automatic testIllegal(input opcodeT op, input functT fn);
        runInstr(op, fn, 1'b0, 1'b0);
        checkException(12);
    endtask

    task automatic runRandomMix(input int count);
        int k;
        for (k = 0; k < count; k++) begin
            case ($urandom % 13)
                0: testAlu(`OP_RTYPE, `FN_ADD, ($urandom % 2) == 1, `ALU_ADD, `DST_RD,
                           `DS_ALUOUT, 9, 1'b1);
                1: testAlu(`OP_RTYPE, `FN_SUB, ($urandom % 2) == 1, `ALU_SUB, `DST_RD,
                           `DS_ALUOUT, 9, 1'b1);
                2: testAlu(`OP_RTYPE, `FN_AND, ($urandom % 2) == 1, `ALU_AND, `DST_RD,
                           `DS_ALUOUT, 9, 1'b0);
                3: testAlu(`OP_RTYPE, `FN_SLT, ($urandom % 2) == 1, `ALU_CMP, `DST_RD,
                           `DS_LT, 7, 1'b0);
                4: testAlu(`OP_ADDI, functT'($urandom), ($urandom % 2) == 1, `ALU_ADD, `DST_RT,
                           `DS_ALUOUT, 9, 1'b1);
                5: testAlu(`OP_ADDIU, functT'($urandom), ($urandom % 2) == 1, `ALU_ADD, `DST_RT,
                           `DS_ALUOUT, 9, 1'b0);
                6: testShift(`FN_SRA, `SH_RIGHTA);
                7: testBranch(`OP_BEQ);
                8: testBranch(`OP_BNE);
                9: testJump();
                10: testLoad();
                11: testStore();
                default: testIllegal(6'h3f, functT'($urandom));
            endcase
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        eq       = 1'b0;
        void'($urandom(32'he30a));
        applyReset();
        testAlu(`OP_RTYPE, `FN_ADD, 1'b0, `ALU_ADD, `DST_RD, `DS_ALUOUT, 9, 1'b1);
        testAlu(`OP_RTYPE, `FN_SUB, 1'b0, `ALU_SUB, `DST_RD, `DS_ALUOUT, 9, 1'b1);
        testAlu(`OP_RTYPE, `FN_AND, 1'b1, `ALU_AND, `DST_RD, `DS_ALUOUT, 9, 1'b0);
        testAlu(`OP_RTYPE, `FN_SLT, 1'b0, `ALU_CMP, `DST_RD, `DS_LT, 7, 1'b0);
        testAlu(`OP_ADDI, 6'h15, 1'b0, `ALU_ADD, `DST_RT, `DS_ALUOUT, 9, 1'b1);
        testAlu(`OP_ADDIU, 6'h20, 1'b1, `ALU_ADD, `DST_RT, `DS_ALUOUT, 9, 1'b0);
        testShift(`FN_SLL, `SH_LEFT);
        testShift(`FN_SRL, `SH_RIGHTL);
        testShift(`FN_SRA, `SH_RIGHTA);
        repeat (3) testBranch(`OP_BEQ);
        repeat (3) testBranch(`OP_BNE);
        testJump();
        testLoad();
        testStore();
        testIllegal(6'h3f, 6'h00);      // unknown opcode
        testIllegal(`OP_RTYPE, 6'h01);  // unknown funct
        testAlu(`OP_RTYPE, `FN_ADD, 1'b1, `ALU_ADD, `DST_RD, `DS_ALUOUT, 9, 1'b1);
        testAlu(`OP_RTYPE, `FN_SUB, 1'b1, `ALU_SUB, `DST_RD, `DS_ALUOUT, 9, 1'b1);
        testAlu(`OP_ADDI, 6'h2a, 1'b1, `ALU_ADD, `DST_RT, `DS_ALUOUT, 9, 1'b1);
        runRandomMix(24);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
controlPkg.sv
instrDecoder.sv
ctrlSequencer.sv
ctrlEncoder.sv
controlUnit.sv
tbControlUnit.sv
